// ==== verilog/agc_pkg.sv ====
package agc_pkg;

    localparam int AMPLITUDE_DATA_SIZE = 13;   // Samples, amplitudes, target and error
    localparam int UART_DATA_SIZE      = 8;
    localparam int GAIN_SIZE           = 8;

    // Status word of the AGC core, encodings match the existing status bus
    typedef enum logic [3:0] {
        IAGC_RESET = 4'b0000,
        IAGC_INIT  = 4'b0001,
        IAGC_TRACK = 4'b0010,
        IAGC_LOG   = 4'b1110
    } iagc_status_e;

    typedef enum logic [2:0] {
        ST_INIT,                               // Parked until the core logs
        ST_WAIT,                               // Interval timer running
        ST_SNAP,                               // Capture report for one record
        ST_SEND,                               // Start pulse to the UART
        ST_SETTLE,                             // Let ready drop
        ST_DRAIN                               // Wait for the frame to finish
    } logger_state_e;

    typedef struct packed {
        logic [AMPLITUDE_DATA_SIZE-1:0] reference;   // Block peak magnitude
        logic [AMPLITUDE_DATA_SIZE-1:0] error;       // Target minus reference
    } amp_report_t;

endpackage

// ==== verilog/iagc_core.sv ====
module iagc_core
    import agc_pkg::*;
#(
    parameter int BLOCK_LEN = 64
) (
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_enable,
    input  logic signed [AMPLITUDE_DATA_SIZE-1:0] i_sample,
    input  logic                                  i_sample_valid,
    input  logic        [AMPLITUDE_DATA_SIZE-1:0] i_target,
    output amp_report_t                           o_report,
    output logic        [GAIN_SIZE-1:0]           o_gain,
    output iagc_status_e                          o_status
);

    localparam int CNT_W = $clog2(BLOCK_LEN + 1);
    localparam logic [GAIN_SIZE-1:0] GAIN_MID = GAIN_SIZE'(1) << (GAIN_SIZE - 1);

    logic [CNT_W-1:0]               sample_cnt;
    logic [AMPLITUDE_DATA_SIZE-1:0] sample_mag;
    logic [AMPLITUDE_DATA_SIZE-1:0] peak;
    logic [AMPLITUDE_DATA_SIZE-1:0] peak_next;
    logic [AMPLITUDE_DATA_SIZE-1:0] block_peak;
    logic [AMPLITUDE_DATA_SIZE:0]   diff;
    logic                           measuring;
    logic                           block_last;
    logic                           block_done;

    assign measuring  = (o_status == IAGC_TRACK) || (o_status == IAGC_LOG);
    assign sample_mag = i_sample[AMPLITUDE_DATA_SIZE-1] ? $unsigned(-i_sample)
                                                        : $unsigned(i_sample);
    assign peak_next  = (sample_mag > peak) ? sample_mag : peak;
    assign block_last = i_enable && measuring && i_sample_valid &&
                        (sample_cnt == CNT_W'(BLOCK_LEN - 1));

    // One extra bit keeps the true sign even when the 13-bit error wraps
    assign diff = {1'b0, i_target} - {1'b0, block_peak};

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status <= IAGC_RESET;
        end else if (!i_enable) begin
            o_status <= IAGC_RESET;
        end else begin
            case (o_status)
                IAGC_RESET: o_status <= IAGC_INIT;
                IAGC_INIT:  o_status <= IAGC_TRACK;
                IAGC_TRACK: begin
                    if (block_done) begin
                        o_status <= IAGC_LOG;
                    end
                end
                IAGC_LOG:   o_status <= IAGC_LOG;
                default:    o_status <= IAGC_RESET;
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sample_cnt <= '0;
            peak       <= '0;
            block_done <= 1'b0;
        end else begin
            block_done <= block_last;
            if (!i_enable) begin
                sample_cnt <= '0;                        // Partial block is discarded
                peak       <= '0;
            end else if (block_last) begin
                sample_cnt <= '0;
                peak       <= '0;
            end else if (measuring && i_sample_valid) begin
                sample_cnt <= sample_cnt + 1'b1;
                peak       <= peak_next;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (block_last) begin
            block_peak <= peak_next;                     // Includes the last sample
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_report <= '0;
            o_gain   <= GAIN_MID;
        end else if (block_done && i_enable) begin
            o_report.reference <= block_peak;
            o_report.error     <= diff[AMPLITUDE_DATA_SIZE-1:0];
            if (!diff[AMPLITUDE_DATA_SIZE] && (diff != '0) && (o_gain != '1)) begin
                o_gain <= o_gain + 1'b1;
            end else if (diff[AMPLITUDE_DATA_SIZE] && (o_gain != '0)) begin
                o_gain <= o_gain - 1'b1;
            end
        end
    end

    a_status_legal: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_status inside {IAGC_RESET, IAGC_INIT, IAGC_TRACK, IAGC_LOG});

endmodule

// ==== verilog/telemetry_logger.sv ====
module telemetry_logger
    import agc_pkg::*;
#(
    parameter int LOG_INTERVAL = 100000
) (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  iagc_status_e              i_status,
    input  amp_report_t               i_report,
    input  logic                      i_tx_ready,
    output logic [UART_DATA_SIZE-1:0] o_tx_data,
    output logic                      o_tx_start
);

    localparam int CNT_W = $clog2(LOG_INTERVAL + 1);
    localparam int HIGH_BITS = AMPLITUDE_DATA_SIZE - UART_DATA_SIZE;

    logger_state_e     state;
    logic [CNT_W-1:0]  interval_cnt;
    logic [1:0]        byte_idx;
    amp_report_t       snap;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= ST_INIT;
            interval_cnt <= '0;
            byte_idx     <= '0;
            snap         <= '0;
        end else begin
            case (state)
                ST_INIT: begin
                    interval_cnt <= '0;
                    if (i_status == IAGC_LOG) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_status != IAGC_LOG) begin
                        state <= ST_INIT;
                    end else if (interval_cnt == CNT_W'(LOG_INTERVAL - 1)) begin
                        state <= ST_SNAP;
                    end else begin
                        interval_cnt <= interval_cnt + 1'b1;
                    end
                end
                ST_SNAP: begin
                    snap     <= i_report;                // All four bytes from one block
                    byte_idx <= '0;
                    state    <= ST_SEND;
                end
                ST_SEND: begin
                    state <= ST_SETTLE;
                end
                ST_SETTLE: begin
                    state <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (i_tx_ready) begin
                        if (byte_idx == 2'd3) begin
                            interval_cnt <= '0;
                            state        <= ST_WAIT;     // Record in flight always finishes
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= ST_SEND;
                        end
                    end
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

    always_comb begin
        case (byte_idx)
            2'd0:    o_tx_data = snap.reference[UART_DATA_SIZE-1:0];
            2'd1:    o_tx_data = UART_DATA_SIZE'(snap.reference[AMPLITUDE_DATA_SIZE-1 -: HIGH_BITS]);
            2'd2:    o_tx_data = snap.error[UART_DATA_SIZE-1:0];
            default: o_tx_data = UART_DATA_SIZE'(snap.error[AMPLITUDE_DATA_SIZE-1 -: HIGH_BITS]);
        endcase
    end

    // SEND is only entered after ready was seen high
    assign o_tx_start = (state == ST_SEND);

    a_send_needs_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (state == ST_SEND) |-> i_tx_ready);

    a_start_single: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_tx_start |=> !o_tx_start);

endmodule

// ==== verilog/uart_tx.sv ====
module uart_tx
    import agc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                      i_clock,
    input  logic                      i_rst_n,
    input  logic [UART_DATA_SIZE-1:0] i_tx_data,
    input  logic                      i_tx_start,
    output logic                      o_tx_ready,
    output logic                      o_uart_tx
);

    localparam int FRAME_BITS = UART_DATA_SIZE + 2;  // Start, data, stop
    localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
    localparam int BIT_W = $clog2(FRAME_BITS);

    logic [BAUD_W-1:0]       baud_cnt;
    logic [BIT_W-1:0]        bit_cnt;
    logic [UART_DATA_SIZE:0] shreg;                 // Stop bit above the data byte
    logic                    busy;
    logic                    line;
    logic                    baud_tick;

    assign baud_tick = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            line     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (i_tx_start) begin
                busy <= 1'b1;
                line <= 1'b0;                        // Start bit
            end
        end else if (baud_tick) begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                busy <= 1'b0;                        // Stop bit period done
            end else begin
                line    <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!busy && i_tx_start) begin
            shreg <= {1'b1, i_tx_data};
        end else if (busy && baud_tick) begin
            shreg <= {1'b1, shreg[UART_DATA_SIZE:1]}; // LSB first
        end
    end

    assign o_tx_ready = !busy;
    assign o_uart_tx  = line;

    a_idle_line_high: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_tx_ready |-> o_uart_tx);

endmodule

// ==== verilog/agc_telemetry_top.sv ====
module agc_telemetry_top
    import agc_pkg::*;
#(
    parameter int BLOCK_LEN    = 64,
    parameter int LOG_INTERVAL = 100000,
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_enable,
    input  logic signed [AMPLITUDE_DATA_SIZE-1:0] i_sample,
    input  logic                                  i_sample_valid,
    input  logic        [AMPLITUDE_DATA_SIZE-1:0] i_target,
    output logic                                  o_uart_tx,
    output logic        [GAIN_SIZE-1:0]           o_gain,
    output iagc_status_e                          o_status
);

    amp_report_t               report;
    logic [UART_DATA_SIZE-1:0] tx_data;
    logic                      tx_start;
    logic                      tx_ready;

    iagc_core #(
        .BLOCK_LEN      (BLOCK_LEN)
    ) iagc_core_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_enable       (i_enable),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .i_target       (i_target),
        .o_report       (report),
        .o_gain         (o_gain),
        .o_status       (o_status)
    );

    telemetry_logger #(
        .LOG_INTERVAL   (LOG_INTERVAL)
    ) telemetry_logger_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_status       (o_status),
        .i_report       (report),
        .i_tx_ready     (tx_ready),
        .o_tx_data      (tx_data),
        .o_tx_start     (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) uart_tx_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_tx_data      (tx_data),
        .i_tx_start     (tx_start),
        .o_tx_ready     (tx_ready),
        .o_uart_tx      (o_uart_tx)
    );

endmodule

// ==== bench/tb_agc_telemetry.sv ====
module tb_agc_telemetry
    import agc_pkg::*;
;

    localparam int BLOCK_LEN    = 8;
    localparam int LOG_INTERVAL = 40;
    localparam int CLKS_PER_BIT = 4;
    localparam int GOAL_LOG     = 0;
    localparam int GOAL_GAIN    = 1;
    localparam int GOAL_RECORDS = 2;
    localparam int GOAL_QUIET   = 3;

    logic                                  i_clock;
    logic                                  i_rst_n;
    logic                                  i_enable;
    logic signed [AMPLITUDE_DATA_SIZE-1:0] i_sample;
    logic                                  i_sample_valid;
    logic        [AMPLITUDE_DATA_SIZE-1:0] i_target;
    logic                                  o_uart_tx;
    logic        [GAIN_SIZE-1:0]           o_gain;
    iagc_status_e                          o_status;

    int                             seed = 43239;
    int                             mismatch_count = 0;
    int                             other_count = 0;
    iagc_status_e                   m_status = IAGC_RESET;   // Reference model of the core
    int                             m_cnt = 0;
    int                             m_peak = 0;
    int                             m_pend = 0;
    int                             m_pend_peak = 0;
    int                             m_gain = 128;
    int                             hist_ref[$];             // Completed blocks
    int                             hist_err[$];
    logic                           cur_enable;
    logic [AMPLITUDE_DATA_SIZE-1:0] cur_target;
    logic [31:0]                    pick;
    int                             starts;
    int                             rx_active = 0;           // UART line decoder
    int                             rx_tick = 0;
    int                             rx_bit_pos = 0;
    logic [UART_DATA_SIZE-1:0]      rx_shift = '0;
    logic [UART_DATA_SIZE-1:0]      rec_bytes[4];
    int                             rec_fill = 0;
    int                             rec_count = 0;
    int                             frame_starts = 0;
    int                             quiet_cycles = 0;

    agc_telemetry_top #(
        .BLOCK_LEN      (BLOCK_LEN),
        .LOG_INTERVAL   (LOG_INTERVAL),
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) agc_telemetry_top_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_enable       (i_enable),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .i_target       (i_target),
        .o_uart_tx      (o_uart_tx),
        .o_gain         (o_gain),
        .o_status       (o_status)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task report_problem(input string text);
        other_count++;
        $display("ERROR %s", text);
    endtask

    // Drives one cycle on the falling edge and advances the model to the next one
    task step_cycle;
        logic [31:0] r;
        int          mag;
        int          d;
        int          new_pend;
        int          new_peak;
        bit          measuring;
        r = $random(seed);
        i_enable       = cur_enable;
        i_target       = cur_target;
        i_sample       = r[AMPLITUDE_DATA_SIZE-1:0];
        i_sample_valid = (r[31:30] != 2'b00);                // Random gaps
        measuring = (m_status == IAGC_TRACK) || (m_status == IAGC_LOG);
        new_pend  = 0;
        new_peak  = 0;
        mag = int'(i_sample);
        if (mag < 0) begin
            mag = -mag;
        end
        if (!cur_enable) begin
            m_cnt  = 0;
            m_peak = 0;
        end else if (measuring && i_sample_valid) begin
            if (mag > m_peak) begin
                m_peak = mag;
            end
            if (m_cnt == BLOCK_LEN - 1) begin
                new_pend = 1;
                new_peak = m_peak;
                m_cnt    = 0;
                m_peak   = 0;
            end else begin
                m_cnt++;
            end
        end
        if (m_pend != 0 && cur_enable) begin                 // Report one cycle after the block
            d = int'(cur_target) - m_pend_peak;
            hist_ref.push_back(m_pend_peak);
            hist_err.push_back(d & 32'h1fff);
            if (d > 0 && m_gain < 255) begin
                m_gain++;
            end else if (d < 0 && m_gain > 0) begin
                m_gain--;
            end
        end
        if (!cur_enable) begin
            m_status = IAGC_RESET;
        end else if (m_status == IAGC_RESET) begin
            m_status = IAGC_INIT;
        end else if (m_status == IAGC_INIT) begin
            m_status = IAGC_TRACK;
        end else if (m_pend != 0) begin
            m_status = IAGC_LOG;
        end
        m_pend      = new_pend;
        m_pend_peak = new_peak;
        @(posedge i_clock);
        @(negedge i_clock);
        check_value("o_status", 32'(o_status), 32'(m_status));
        check_value("o_gain", 32'(o_gain), m_gain);
    endtask

    function automatic bit goal_met(input int goal, input int arg);
        case (goal)
            GOAL_LOG:     return o_status == IAGC_LOG;
            GOAL_GAIN:    return int'(o_gain) == arg;
            GOAL_RECORDS: return rec_count >= arg;
            default:      return quiet_cycles >= arg;
        endcase
    endfunction

    task run_until(input int goal, input int arg, input int limit, input string what);
        int n;
        n = 0;
        while (!goal_met(goal, arg) && n < limit) begin
            step_cycle();
            n++;
        end
        if (!goal_met(goal, arg)) begin
            report_problem($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
        end
    endtask

    task check_record;
        logic [AMPLITUDE_DATA_SIZE-1:0] rec_ref;
        logic [AMPLITUDE_DATA_SIZE-1:0] rec_err;
        int                             first;
        int                             i;
        bit                             pair;
        first   = -1;
        pair    = 0;
        rec_ref = {rec_bytes[1][4:0], rec_bytes[0]};
        rec_err = {rec_bytes[3][4:0], rec_bytes[2]};
        check_value("reference high byte upper bits", 32'(rec_bytes[1][7:5]), 0);
        check_value("error high byte upper bits", 32'(rec_bytes[3][7:5]), 0);
        for (i = hist_ref.size() - 1; i >= 0; i--) begin
            if (hist_ref[i] == int'(rec_ref)) begin
                if (first < 0) begin
                    first = i;
                end
                if (hist_err[i] == int'(rec_err)) begin
                    pair = 1;
                end
            end
        end
        if (first < 0) begin
            report_problem($sformatf("Record reference 0x%0h matches no completed block", rec_ref));
        end else if (!pair) begin
            check_value("record error", 32'(rec_err), 32'(hist_err[first]));
        end
        rec_count++;
    endtask

    // Samples the line 1.5 clocks into each bit period
    always @(negedge i_clock) begin
        if (rx_active == 0) begin
            if (i_rst_n && !o_uart_tx) begin
                rx_active = 1;
                rx_tick   = 0;
                frame_starts++;
            end
        end else begin
            rx_tick++;
            if ((rx_tick - 1) % CLKS_PER_BIT == 0) begin
                rx_bit_pos = (rx_tick - 1) / CLKS_PER_BIT;
                if (rx_bit_pos == 0 && o_uart_tx) begin
                    report_problem("Start bit did not stay low on the UART line");
                end else if (rx_bit_pos >= 1 && rx_bit_pos <= 8) begin
                    rx_shift = {o_uart_tx, rx_shift[7:1]};    // LSB first
                end else if (rx_bit_pos == 9) begin
                    if (!o_uart_tx) begin
                        report_problem("Stop bit missing on the UART line");
                    end
                    rec_bytes[rec_fill[1:0]] = rx_shift;
                    rec_fill++;
                    rx_active = 0;
                    if (rec_fill == 4) begin
                        check_record();
                        rec_fill = 0;
                    end
                end
            end
        end
        if (rx_active == 0 && rec_fill == 0 && o_uart_tx) begin
            quiet_cycles++;
        end else begin
            quiet_cycles = 0;
        end
    end

    initial begin
        i_rst_n        = 1'b0;
        i_enable       = 1'b0;
        i_sample       = '0;
        i_sample_valid = 1'b0;
        i_target       = '0;
        cur_enable     = 1'b0;
        cur_target     = '0;
        repeat (3) @(negedge i_clock);
        i_rst_n = 1'b1;
        repeat (20) begin
            step_cycle();
            check_value("o_uart_tx", 32'(o_uart_tx), 1);
        end
        pick       = $random(seed);
        cur_target = pick[AMPLITUDE_DATA_SIZE-1:0];
        cur_enable = 1'b1;
        run_until(GOAL_LOG, 0, 200, "status LOG after the first block");
        cur_target = '1;                                     // Above any block peak
        run_until(GOAL_GAIN, 255, 8000, "the gain to reach its upper limit");
        run_until(GOAL_RECORDS, rec_count + 3, 2000, "records at the gain limit");
        repeat (4) begin
            pick       = $random(seed);
            cur_target = pick[AMPLITUDE_DATA_SIZE-1:0];
            run_until(GOAL_RECORDS, rec_count + 2, 2000, "records after a target change");
        end
        cur_target = '0;
        run_until(GOAL_RECORDS, rec_count + 2, 2000, "records with a zero target");
        cur_enable = 1'b0;
        run_until(GOAL_QUIET, 12, 1000, "the UART line to go quiet after disabling");
        starts = frame_starts;
        repeat (3 * LOG_INTERVAL) step_cycle();
        check_value("frame_starts", frame_starts, starts);
        pick       = $random(seed);
        cur_target = pick[AMPLITUDE_DATA_SIZE-1:0];
        cur_enable = 1'b1;
        run_until(GOAL_RECORDS, rec_count + 2, 2000, "records after enabling again");
        $display("Checks done with %0d value mismatches and %0d other errors in %0d records",
                 mismatch_count, other_count, rec_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/agc_pkg.sv
verilog/iagc_core.sv
verilog/telemetry_logger.sv
verilog/uart_tx.sv
verilog/agc_telemetry_top.sv
bench/tb_agc_telemetry.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_agc_telemetry -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
